/* axi_lite_read_xbar.f */
rtl/axi_lite_pkg.sv
rtl/xbar_map_pkg.sv
rtl/ar_skid_buffer.sv
rtl/ar_decoder.sv
rtl/read_arbiter.sv
rtl/slave_read_port.sv
rtl/read_return.sv
rtl/axi_lite_read_xbar.sv
testbench/tb_slave_model.sv
testbench/tb_axi_lite_read_xbar.sv

/* rtl/ar_decoder.sv */
module ar_decoder
	import axi_lite_pkg::*, xbar_map_pkg::*;
(
	input  logic     S_AXI_ACLK,
	input  logic     S_AXI_ARESETN,
	input  logic     i_valid,
	output logic     o_ready,
	input  ar_req_t  i_req,
	output logic     o_valid,
	input  logic     i_take,
	output dec_req_t o_dec
);

	target_t hit;

	always_comb
	begin
		hit = '0;
		for (int k = 0; k < NS; k++)
		begin
			hit[k] = (i_req.addr & SLAVE_MASK[k]) == SLAVE_BASE[k];
		end
		// nothing matched, send to the error target
		hit[NS] = ~|hit[NS-1:0];
	end

	// free when empty or drained this cycle
	assign o_ready = !o_valid || i_take;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_valid <= 1'b0;
		end
		else if (o_ready)
		begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready && i_valid)
		begin
			o_dec.ar     <= i_req;
			o_dec.target <= hit;
		end
	end

endmodule

/* rtl/ar_skid_buffer.sv */
module ar_skid_buffer
	import axi_lite_pkg::*;
(
	input  logic    S_AXI_ACLK,
	input  logic    S_AXI_ARESETN,
	input  logic    i_valid,
	output logic    o_ready,
	input  ar_req_t i_req,
	output logic    o_valid,
	input  logic    i_ready,
	output ar_req_t o_req
);

	logic    skid_valid;
	ar_req_t skid_req;

	// ready only depends on the skid register
	assign o_ready = !skid_valid;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			skid_valid <= 1'b0;
		end
		else if (i_valid && o_ready && !i_ready)
		begin
			// downstream stalled while we accepted a word
			skid_valid <= 1'b1;
		end
		else if (i_ready)
		begin
			skid_valid <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
		begin
			skid_req <= i_req;
		end
	end

	// pass through while the skid register is empty
	assign o_valid = skid_valid || i_valid;
	assign o_req   = skid_valid ? skid_req : i_req;

endmodule

/* rtl/axi_lite_pkg.sv */
package axi_lite_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// AXI response field
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	// interconnect error, returned for unmapped addresses
	localparam resp_t RESP_DECERR = 2'b11;

	// read address channel payload
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} ar_req_t;

	// read data channel payload
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		resp_t             rresp;
	} r_beat_t;

endpackage

/* rtl/axi_lite_read_xbar.sv */
module axi_lite_read_xbar
	import axi_lite_pkg::*, xbar_map_pkg::*;
(
	input  logic                S_AXI_ACLK,
	input  logic                S_AXI_ARESETN,
	input  logic    [NM-1:0]    i_s_arvalid,
	output logic    [NM-1:0]    o_s_arready,
	input  ar_req_t [NM-1:0]    i_s_ar,
	output logic    [NM-1:0]    o_s_rvalid,
	input  logic    [NM-1:0]    i_s_rready,
	output r_beat_t [NM-1:0]    o_s_r,
	output logic    [NS-1:0]    o_m_arvalid,
	input  logic    [NS-1:0]    i_m_arready,
	output ar_req_t [NS-1:0]    o_m_ar,
	input  logic    [NS-1:0]    i_m_rvalid,
	output logic    [NS-1:0]    o_m_rready,
	input  r_beat_t [NS-1:0]    i_m_r
);

	logic     [NM-1:0] skd_valid;
	logic     [NM-1:0] skd_ready;
	ar_req_t  [NM-1:0] skd_req;
	logic     [NM-1:0] dec_valid;
	logic     [NM-1:0] dec_take;
	dec_req_t [NM-1:0] dec_req;
	logic     [NM-1:0] err_valid;
	logic     [NM-1:0] rsp_ready;
	logic     [NM-1:0] rsp_done;
	logic     [NM-1:0] ret_rvalid;
	r_beat_t  [NM-1:0] ret_r;
	logic     [NS-1:0] issue_valid;
	logic     [NS-1:0] issue_ready;
	ar_req_t  [NS-1:0] issue_req;
	mst_idx_t [NS-1:0] owner;
	logic     [NS-1:0] port_rsp_ready;
	logic     [NS-1:0] port_rvalid;
	r_beat_t  [NS-1:0] port_r;

	for (genvar m = 0; m < NM; m++)
	begin : g_master
		ar_skid_buffer u_skid (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.i_valid       (i_s_arvalid[m]),
			.o_ready       (o_s_arready[m]),
			.i_req         (i_s_ar[m]),
			.o_valid       (skd_valid[m]),
			.i_ready       (skd_ready[m]),
			.o_req         (skd_req[m])
		);

		ar_decoder u_dec (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.i_valid       (skd_valid[m]),
			.o_ready       (skd_ready[m]),
			.i_req         (skd_req[m]),
			.o_valid       (dec_valid[m]),
			.i_take        (dec_take[m]),
			.o_dec         (dec_req[m])
		);

		read_return u_ret (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.i_rvalid      (ret_rvalid[m]),
			.i_r           (ret_r[m]),
			.i_err_valid   (err_valid[m]),
			.o_rsp_ready   (rsp_ready[m]),
			.o_s_rvalid    (o_s_rvalid[m]),
			.i_s_rready    (i_s_rready[m]),
			.o_s_r         (o_s_r[m]),
			.o_rsp_done    (rsp_done[m])
		);
	end

	read_arbiter u_arb (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_dec_valid   (dec_valid),
		.i_dec         (dec_req),
		.o_dec_take    (dec_take),
		.o_issue_valid (issue_valid),
		.o_issue_req   (issue_req),
		.i_issue_ready (issue_ready),
		.o_owner       (owner),
		.o_err_valid   (err_valid),
		.i_rsp_ready   (rsp_ready),
		.i_rsp_done    (rsp_done)
	);

	for (genvar k = 0; k < NS; k++)
	begin : g_slave
		slave_read_port u_port (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.i_issue_valid (issue_valid[k]),
			.i_issue_req   (issue_req[k]),
			.o_issue_ready (issue_ready[k]),
			.o_m_arvalid   (o_m_arvalid[k]),
			.i_m_arready   (i_m_arready[k]),
			.o_m_ar        (o_m_ar[k]),
			.i_m_rvalid    (i_m_rvalid[k]),
			.o_m_rready    (o_m_rready[k]),
			.i_m_r         (i_m_r[k]),
			.i_rsp_ready   (port_rsp_ready[k]),
			.o_rvalid      (port_rvalid[k]),
			.o_r           (port_r[k])
		);
	end

	// route R beats by owner, a master holds one slave at a time
	always_comb
	begin
		ret_rvalid = '0;
		ret_r      = '0;
		for (int k = 0; k < NS; k++)
		begin
			port_rsp_ready[k] = rsp_ready[owner[k]];
			if (port_rvalid[k])
			begin
				ret_rvalid[owner[k]] = 1'b1;
				ret_r[owner[k]]      = port_r[k];
			end
		end
	end

endmodule

/* rtl/read_arbiter.sv */
module read_arbiter
	import axi_lite_pkg::*, xbar_map_pkg::*;
(
	input  logic                S_AXI_ACLK,
	input  logic                S_AXI_ARESETN,
	input  logic     [NM-1:0]   i_dec_valid,
	input  dec_req_t [NM-1:0]   i_dec,
	output logic     [NM-1:0]   o_dec_take,
	output logic     [NS-1:0]   o_issue_valid,
	output ar_req_t  [NS-1:0]   o_issue_req,
	input  logic     [NS-1:0]   i_issue_ready,
	output mst_idx_t [NS-1:0]   o_owner,
	output logic     [NM-1:0]   o_err_valid,
	input  logic     [NM-1:0]   i_rsp_ready,
	input  logic     [NM-1:0]   i_rsp_done
);

	target_t [NM-1:0]             grant;
	target_t [NM-1:0]             next_grant;
	logic    [NM-1:0][CNT_W-1:0]  pending;
	sel_t    [NM-1:0]             sel;
	target_t [NM-1:0]             path_ready;
	logic    [NS-1:0]             owned;
	logic    [NS-1:0]             claimed;

	// which master holds each slave
	always_comb
	begin
		owned   = '0;
		o_owner = '0;
		for (int k = 0; k < NS; k++)
		begin
			for (int m = 0; m < NM; m++)
			begin
				if (grant[m][k])
				begin
					owned[k]   = 1'b1;
					o_owner[k] = mst_idx_t'(m);
				end
			end
		end
	end

	// take only the granted target, and only with room downstream
	always_comb
	begin
		for (int m = 0; m < NM; m++)
		begin
			sel[m] = '0;
			for (int t = 0; t <= NS; t++)
			begin
				if (i_dec[m].target[t])
				begin
					sel[m] = sel_t'(t);
				end
			end
			path_ready[m] = {i_rsp_ready[m], i_issue_ready};
			o_dec_take[m] = i_dec_valid[m] && grant[m][sel[m]]
				&& (pending[m] < MAX_PENDING) && path_ready[m][sel[m]];
			o_err_valid[m] = o_dec_take[m] && (sel[m] == sel_t'(NS));
		end
	end

	always_comb
	begin
		o_issue_valid = '0;
		for (int k = 0; k < NS; k++)
		begin
			for (int m = 0; m < NM; m++)
			begin
				if (o_dec_take[m] && grant[m][k])
				begin
					o_issue_valid[k] = 1'b1;
				end
			end
			o_issue_req[k] = i_dec[o_owner[k]].ar;
		end
	end

	// grant changes only once a master has nothing in flight
	always_comb
	begin
		claimed = '0;
		for (int m = 0; m < NM; m++)
		begin
			next_grant[m] = grant[m];
			if (pending[m] == '0 && !(i_dec_valid[m] && |(grant[m] & i_dec[m].target)))
			begin
				next_grant[m] = '0;
				// lower index masters claimed first in this loop
				if (i_dec_valid[m] && (i_dec[m].target[NS]
					|| !(|(i_dec[m].target[NS-1:0] & (owned | claimed)))))
				begin
					next_grant[m] = i_dec[m].target;
				end
			end
			claimed = claimed | next_grant[m][NS-1:0];
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			grant   <= '0;
			pending <= '0;
		end
		else
		begin
			grant <= next_grant;
			for (int m = 0; m < NM; m++)
			begin
				pending[m] <= pending[m] + CNT_W'(o_dec_take[m]) - CNT_W'(i_rsp_done[m]);
			end
		end
	end

endmodule

/* rtl/read_return.sv */
module read_return
	import axi_lite_pkg::*;
(
	input  logic    S_AXI_ACLK,
	input  logic    S_AXI_ARESETN,
	input  logic    i_rvalid,
	input  r_beat_t i_r,
	input  logic    i_err_valid,
	output logic    o_rsp_ready,
	output logic    o_s_rvalid,
	input  logic    i_s_rready,
	output r_beat_t o_s_r,
	output logic    o_rsp_done
);

	logic    ovf_valid;
	r_beat_t ovf_r;
	logic    beat_valid;
	r_beat_t beat;
	logic    stall;

	// slave beat or locally made DECERR, never both at once
	always_comb
	begin
		beat_valid = i_rvalid || i_err_valid;
		beat       = i_r;
		if (i_err_valid)
		begin
			beat.rdata = '0;
			beat.rresp = RESP_DECERR;
		end
	end

	assign stall       = o_s_rvalid && !i_s_rready;
	assign o_rsp_ready = !ovf_valid;
	assign o_rsp_done  = o_s_rvalid && i_s_rready;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_s_rvalid <= 1'b0;
			ovf_valid  <= 1'b0;
		end
		else if (!stall)
		begin
			o_s_rvalid <= ovf_valid || beat_valid;
			ovf_valid  <= 1'b0;
		end
		else if (beat_valid)
		begin
			// output held, park the new beat
			ovf_valid <= 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!stall)
		begin
			o_s_r <= ovf_valid ? ovf_r : beat;
		end
		if (stall && beat_valid)
		begin
			ovf_r <= beat;
		end
	end

endmodule

/* rtl/slave_read_port.sv */
module slave_read_port
	import axi_lite_pkg::*;
(
	input  logic    S_AXI_ACLK,
	input  logic    S_AXI_ARESETN,
	input  logic    i_issue_valid,
	input  ar_req_t i_issue_req,
	output logic    o_issue_ready,
	output logic    o_m_arvalid,
	input  logic    i_m_arready,
	output ar_req_t o_m_ar,
	input  logic    i_m_rvalid,
	output logic    o_m_rready,
	input  r_beat_t i_m_r,
	input  logic    i_rsp_ready,
	output logic    o_rvalid,
	output r_beat_t o_r
);

	// AR register frees up when empty or when the slave takes it
	assign o_issue_ready = !o_m_arvalid || i_m_arready;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_m_arvalid <= 1'b0;
		end
		else if (o_issue_ready)
		begin
			o_m_arvalid <= i_issue_valid;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_issue_ready && i_issue_valid)
		begin
			o_m_ar <= i_issue_req;
		end
	end

	// owner's return path decides when a beat is taken
	assign o_m_rready = i_rsp_ready;

	// only accepted beats go on to the owner
	assign o_rvalid = i_m_rvalid && i_rsp_ready;
	assign o_r      = i_m_r;

endmodule

/* rtl/xbar_map_pkg.sv */
package xbar_map_pkg;

	import axi_lite_pkg::*;

	localparam int NM = 2;
	localparam int NS = 3;

	// target index covers the slaves plus the error target
	localparam int SEL_W = $clog2(NS + 1);
	localparam int MST_W = (NM > 1) ? $clog2(NM) : 1;

	typedef logic [SEL_W-1:0] sel_t;
	typedef logic [MST_W-1:0] mst_idx_t;

	// one-hot target, bit NS is the error target
	typedef logic [NS:0] target_t;

	// slave k answers on top nibble k+1
	localparam logic [NS-1:0][ADDR_W-1:0] SLAVE_BASE = {
		32'h3000_0000,
		32'h2000_0000,
		32'h1000_0000
	};
	localparam logic [NS-1:0][ADDR_W-1:0] SLAVE_MASK = {
		32'hf000_0000,
		32'hf000_0000,
		32'hf000_0000
	};

	// outstanding reads allowed per master
	localparam int MAX_PENDING = 15;
	localparam int CNT_W = 4;

	// decoded request as handed to the arbiter
	typedef struct packed {
		ar_req_t ar;
		target_t target;
	} dec_req_t;

endpackage

/* testbench/tb_axi_lite_read_xbar.sv */
module tb_axi_lite_read_xbar
	import axi_lite_pkg::*, xbar_map_pkg::*;
();

	localparam int CLK_PERIOD       = 100;
	localparam int READS_PER_MASTER = 200;
	localparam int WATCHDOG_CYCLES  = NM * READS_PER_MASTER * 40;

	logic                S_AXI_ACLK;
	logic                S_AXI_ARESETN;
	logic    [NM-1:0]    s_arvalid;
	logic    [NM-1:0]    s_arready;
	ar_req_t [NM-1:0]    s_ar;
	logic    [NM-1:0]    s_rvalid;
	logic    [NM-1:0]    s_rready;
	r_beat_t [NM-1:0]    s_r;
	logic    [NS-1:0]    m_arvalid;
	logic    [NS-1:0]    m_arready;
	ar_req_t [NS-1:0]    m_ar;
	logic    [NS-1:0]    m_rvalid;
	logic    [NS-1:0]    m_rready;
	r_beat_t [NS-1:0]    m_r;
	logic    [NS-1:0][3:0] slv_rnd;

	logic [15:0] lfsr = 16'd39560;
	int          sent[NM];
	int          wr_ptr[NM];
	int          rd_ptr[NM];
	int          routed[NS];
	int          slv_hs[NS];
	logic        held_valid[NM];
	r_beat_t     held_r[NM];
	r_beat_t     exp_mem[NM][256];
	int          nib;

	axi_lite_read_xbar dut0 (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_s_arvalid   (s_arvalid),
		.o_s_arready   (s_arready),
		.i_s_ar        (s_ar),
		.o_s_rvalid    (s_rvalid),
		.i_s_rready    (s_rready),
		.o_s_r         (s_r),
		.o_m_arvalid   (m_arvalid),
		.i_m_arready   (m_arready),
		.o_m_ar        (m_ar),
		.i_m_rvalid    (m_rvalid),
		.o_m_rready    (m_rready),
		.i_m_r         (m_r)
	);

	for (genvar k = 0; k < NS; k++)
	begin : g_slave
		tb_slave_model #(.SLAVE_IDX(k)) u_slave (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.i_rnd         (slv_rnd[k]),
			.i_arvalid     (m_arvalid[k]),
			.o_arready     (m_arready[k]),
			.i_ar          (m_ar[k]),
			.o_rvalid      (m_rvalid[k]),
			.i_rready      (m_rready[k]),
			.o_r           (m_r[k])
		);
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_step();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	// top nibble 0 to 5, so some reads hit no slave
	function automatic logic [ADDR_W-1:0] random_addr();
		logic [3:0]  top;
		logic [31:0] low;
		top = 4'(rand_bits(3));
		if (top > 4'd5)
		begin
			top = top - 4'd6;
		end
		low = rand_bits(28);
		return {top, low[27:0]};
	endfunction

	// slave k owns top nibble k+1, data is address xor k*0x11111111
	function automatic r_beat_t expected_beat(input logic [ADDR_W-1:0] addr);
		r_beat_t b;
		int      n;
		n = int'(addr[ADDR_W-1 -: 4]);
		if (n >= 1 && n <= NS)
		begin
			b.rdata = addr ^ (32'(n - 1) * 32'h1111_1111);
			b.rresp = RESP_OKAY;
		end
		else
		begin
			b.rdata = '0;
			b.rresp = RESP_DECERR;
		end
		return b;
	endfunction

	function automatic logic all_done();
		logic d;
		d = 1'b1;
		for (int m = 0; m < NM; m++)
		begin
			if (wr_ptr[m] != READS_PER_MASTER || rd_ptr[m] != wr_ptr[m])
			begin
				d = 1'b0;
			end
		end
		return d;
	endfunction

	task automatic stop_with_error(input string why);
		$display("Checks failed");
		$display("%s", why);
		$fatal(1, "simulation stopped on first error");
	endtask

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	always @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			s_arvalid <= '0;
			s_rready  <= '0;
			slv_rnd   <= '0;
		end
		else
		begin
			for (int m = 0; m < NM; m++)
			begin
				if (s_arvalid[m] && s_arready[m])
				begin
					sent[m] = sent[m] + 1;
				end
				// address held until the crossbar takes it
				if (!s_arvalid[m] || s_arready[m])
				begin
					if (sent[m] < READS_PER_MASTER && lfsr_step())
					begin
						s_arvalid[m]   <= 1'b1;
						s_ar[m].addr <= random_addr();
					end
					else
					begin
						s_arvalid[m] <= 1'b0;
					end
				end
				s_rready[m] <= lfsr_step() | lfsr_step();
			end
			for (int k = 0; k < NS; k++)
			begin
				slv_rnd[k] <= 4'(rand_bits(4));
			end
		end
	end

	// reference model and per-cycle checks
	always @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int m = 0; m < NM; m++)
			begin
				held_valid[m] = 1'b0;
			end
		end
		else
		begin
			for (int m = 0; m < NM; m++)
			begin
				if (s_arvalid[m] && s_arready[m])
				begin
					exp_mem[m][wr_ptr[m]] = expected_beat(s_ar[m].addr);
					wr_ptr[m] = wr_ptr[m] + 1;
					nib = int'(s_ar[m].addr[ADDR_W-1 -: 4]);
					if (nib >= 1 && nib <= NS)
					begin
						routed[nib-1] = routed[nib-1] + 1;
					end
				end
				if (held_valid[m])
				begin
					assert (s_rvalid[m])
					else stop_with_error($sformatf("o_s_rvalid[%0d] dropped while stalled", m));
					assert (s_r[m] == held_r[m])
					else stop_with_error($sformatf("FAILED o_s_r[%0d] under stall: got 0x%h expected 0x%h",
						m, s_r[m], held_r[m]));
				end
				if (s_rvalid[m] && s_rready[m])
				begin
					assert (rd_ptr[m] != wr_ptr[m])
					else stop_with_error($sformatf("master %0d got a response with no read open", m));
					assert (s_r[m] == exp_mem[m][rd_ptr[m]])
					else stop_with_error($sformatf("FAILED o_s_r[%0d]: got 0x%h expected 0x%h",
						m, s_r[m], exp_mem[m][rd_ptr[m]]));
					rd_ptr[m] = rd_ptr[m] + 1;
				end
				held_valid[m] = s_rvalid[m] && !s_rready[m];
				held_r[m]     = s_r[m];
			end
			for (int k = 0; k < NS; k++)
			begin
				if (m_arvalid[k])
				begin
					assert (m_ar[k].addr[ADDR_W-1 -: 4] == 4'(k + 1))
					else stop_with_error($sformatf("FAILED o_m_ar[%0d].addr: got 0x%h expected 0x%0hxxxxxxx",
						k, m_ar[k].addr, k + 1));
					if (m_arready[k])
					begin
						slv_hs[k] = slv_hs[k] + 1;
					end
				end
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_with_error("timeout, not all reads completed in time");
	end

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		s_arvalid     = '0;
		s_ar          = '0;
		s_rready      = '0;
		slv_rnd       = '0;
		repeat (2) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		@(negedge S_AXI_ACLK);
		assert (s_rvalid == '0)
		else stop_with_error($sformatf("FAILED o_s_rvalid after reset: got 0x%h expected 0x0", s_rvalid));
		assert (m_arvalid == '0)
		else stop_with_error($sformatf("FAILED o_m_arvalid after reset: got 0x%h expected 0x0", m_arvalid));
		assert (s_arready == '1)
		else stop_with_error($sformatf("FAILED o_s_arready after reset: got 0x%h expected 0x%h",
			s_arready, {NM{1'b1}}));
		while (!all_done())
		begin
			@(negedge S_AXI_ACLK);
		end
		// idle time so that a duplicate beat would still show up
		repeat (20) @(negedge S_AXI_ACLK);
		for (int k = 0; k < NS; k++)
		begin
			assert (slv_hs[k] == routed[k])
			else stop_with_error($sformatf("FAILED o_m_arvalid[%0d] handshakes: got 0x%h expected 0x%h",
				k, slv_hs[k], routed[k]));
		end
		$display("All checks passed");
		$finish;
	end

endmodule

/* testbench/tb_slave_model.sv */
module tb_slave_model
	import axi_lite_pkg::*;
#(
	parameter int SLAVE_IDX = 0
)
(
	input  logic       S_AXI_ACLK,
	input  logic       S_AXI_ARESETN,
	input  logic [3:0] i_rnd,
	input  logic       i_arvalid,
	output logic       o_arready,
	input  ar_req_t    i_ar,
	output logic       o_rvalid,
	input  logic       i_rready,
	output r_beat_t    o_r
);

	logic [ADDR_W-1:0] pend_q[$];
	logic [ADDR_W-1:0] addr;
	int                wait_cnt;

	initial
	begin
		o_arready = 1'b0;
		o_rvalid  = 1'b0;
		o_r       = '0;
	end

	always @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_arready <= 1'b0;
			o_rvalid  <= 1'b0;
			wait_cnt  <= 0;
			pend_q.delete();
		end
		else
		begin
			// accepted addresses are answered in order
			if (i_arvalid && o_arready)
			begin
				pend_q.push_back(i_ar.addr);
			end
			o_arready <= i_rnd[0];
			if (o_rvalid && i_rready)
			begin
				o_rvalid <= 1'b0;
			end
			if (wait_cnt != 0)
			begin
				wait_cnt <= wait_cnt - 1;
			end
			else if ((!o_rvalid || i_rready) && pend_q.size() != 0)
			begin
				addr = pend_q.pop_front();
				o_rvalid  <= 1'b1;
				o_r.rdata <= addr ^ (32'(SLAVE_IDX) * 32'h1111_1111);
				o_r.rresp <= RESP_OKAY;
				// random gap before the next answer
				wait_cnt  <= int'(i_rnd[3:1]);
			end
		end
	end

endmodule
